/* list.f */
common/fetch_pkg.sv
fetch/pc_counter.sv
fetch/instr_mem.sv
src/fetch_ctrl.sv
src/if_id_reg.sv
src/fetch_stage.sv
verif/fetch_clkgen.sv
verif/fetch_chk.sv
verif/fetch_tb.sv

/* verif/fetch_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_tb
	import fetch_pkg::*;
;

	localparam int MEM_DEPTH   = 64;
	localparam int SEED        = 45857;
	localparam int TIMEOUT     = 200;
	localparam int WATCHDOG_NS = 200000;
	// Program layout, halt right after the last random word
	localparam int PROG_LEN    = 20;

	logic       clk;
	logic       reset;
	logic       start;
	logic       stall;
	redirect_t  redirect;
	load_t      load;
	fetch_out_t if_out;
	logic       halted;
	word_t      pc;

	// Mirror of every debug write
	word_t model [MEM_DEPTH];
	// Observed and expected record streams
	fetch_out_t stream [$];
	fetch_out_t exp_q [$];
	fetch_out_t last_rec;

	int value_errors;
	int timeout_errors;
	int other_errors;
	int assert_errors;

	fetch_clkgen #(
		.PERIOD_NS (20)
	) clkgen0 (
		.clk (clk)
	);

	fetch_stage #(
		.MEM_DEPTH (MEM_DEPTH)
	) dut0 (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.stall    (stall),
		.redirect (redirect),
		.load     (load),
		.if_out   (if_out),
		.halted   (halted),
		.pc       (pc)
	);

	//////////////////////////////////////////////////////////////////////
	// Output monitor
	//////////////////////////////////////////////////////////////////////

	// Sampled mid-cycle, one entry per new valid record
	always @(negedge clk)
	begin
		if (!reset && if_out.valid && (if_out != last_rec))
		begin
			stream.push_back(if_out);
			last_rec = if_out;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
		begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_out(input string name, input fetch_out_t exp, input fetch_out_t act);
		if (act !== exp)
		begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("error %s: expected %b, actual %b", name, exp, act);
			value_errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Any word except the halt word
	function automatic word_t random_word();
		word_t w;
		do
		begin
			w = $urandom;
		end
		while (w == HALT_WORD);
		return w;
	endfunction

	// Record expected when the word at addr is fetched
	function automatic fetch_out_t make_rec(input word_t addr);
		fetch_out_t r;
		r.instr       = model[addr % MEM_DEPTH];
		r.pc_plus_one = addr + 1;
		r.valid       = 1'b1;
		return r;
	endfunction

	task automatic drive_idle();
		start    = 1'b0;
		stall    = 1'b0;
		redirect = '0;
		load     = '0;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		drive_idle();
		reset = 1'b1;
		repeat (10) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic clear_stream();
		stream.delete();
		exp_q.delete();
		last_rec = '0;
	endtask

	task automatic write_word(input word_t addr, input word_t data);
		load.we   = 1'b1;
		load.addr = addr;
		load.data = data;
		model[addr % MEM_DEPTH] = data;
		@(negedge clk);
	endtask

	// Random body then the halt word
	task automatic load_program();
		for (int i = 0; i < PROG_LEN; i++)
		begin
			write_word(i, random_word());
		end
		write_word(PROG_LEN, HALT_WORD);
		load = '0;
	endtask

	task automatic pulse_start();
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_pc(input string name, input word_t target);
		int cycles;
		cycles = 0;
		while ((pc !== target) && (cycles < TIMEOUT))
		begin
			@(negedge clk);
			cycles++;
		end
		if (pc !== target)
		begin
			$display("%s: pc never reached %0d before the timeout", name, target);
			timeout_errors++;
		end
	endtask

	task automatic wait_halted(input string name);
		int cycles;
		cycles = 0;
		while ((halted !== 1'b1) && (cycles < TIMEOUT))
		begin
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1)
		begin
			$display("%s: stage did not halt before the timeout", name);
			timeout_errors++;
		end
	endtask

	task automatic expect_range(input int first, input int last);
		for (int i = first; i <= last; i++)
		begin
			exp_q.push_back(make_rec(i));
		end
	endtask

	task automatic compare_stream(input string name);
		int n;
		if (stream.size() != exp_q.size())
		begin
			$display("%s: stream holds %0d records where %0d were expected",
				name, stream.size(), exp_q.size());
			other_errors++;
		end
		n = (stream.size() < exp_q.size()) ? stream.size() : exp_q.size();
		for (int i = 0; i < n; i++)
		begin
			check_out($sformatf("%s record %0d", name, i), exp_q[i], stream[i]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic reset_defaults();
		apply_reset();
		check_bit("reset_defaults valid", 1'b0, if_out.valid);
		check_bit("reset_defaults halted", 1'b0, halted);
		check_word("reset_defaults pc", '0, pc);
		load_program();
		// Idle, nothing moves
		repeat (3)
		begin
			@(negedge clk);
			check_word("reset_defaults idle pc", '0, pc);
			check_bit("reset_defaults idle valid", 1'b0, if_out.valid);
		end
		pulse_start();
		check_word("reset_defaults pc after start", '0, pc);
		// One record per cycle from address 0
		@(negedge clk);
		check_word("reset_defaults pc step 1", 1, pc);
		check_out("reset_defaults record 0", make_rec(0), if_out);
		@(negedge clk);
		check_word("reset_defaults pc step 2", 2, pc);
		check_out("reset_defaults record 1", make_rec(1), if_out);
		wait_halted("reset_defaults");
	endtask

	task automatic load_and_run();
		apply_reset();
		load_program();
		clear_stream();
		pulse_start();
		wait_halted("load_and_run");
		expect_range(0, PROG_LEN - 1);
		compare_stream("load_and_run");
		check_word("load_and_run halt pc", PROG_LEN, pc);
		check_bit("load_and_run halted", 1'b1, halted);
	endtask

	task automatic stall_freeze();
		int cycles;
		word_t pc_before;
		logic held;
		apply_reset();
		clear_stream();
		pulse_start();
		cycles = 0;
		while ((halted !== 1'b1) && (cycles < TIMEOUT))
		begin
			pc_before = pc;
			stall = (($urandom % 2) == 1);
			held = stall;
			@(negedge clk);
			// Frozen PC across a stalled edge
			if (held)
			begin
				check_word("stall_freeze held pc", pc_before, pc);
			end
			cycles++;
		end
		stall = 1'b0;
		if (halted !== 1'b1)
		begin
			$display("stall_freeze: stage did not halt before the timeout");
			timeout_errors++;
		end
		expect_range(0, PROG_LEN - 1);
		compare_stream("stall_freeze");
		check_word("stall_freeze halt pc", PROG_LEN, pc);
	endtask

	// One redirect at the current PC, then bubble and target record
	task automatic redirect_once(input string name, input pc_src_e src, input word_t target);
		redirect.src           = src;
		redirect.jump_target   = (src == PC_JUMP) ? target : random_word();
		redirect.branch_target = (src == PC_BRANCH) ? target : random_word();
		redirect.reg_target    = (src == PC_REG) ? target : random_word();
		@(negedge clk);
		redirect = '0;
		check_bit({name, " bubble valid"}, 1'b0, if_out.valid);
		check_word({name, " target pc"}, target, pc);
		@(negedge clk);
		check_out({name, " target record"}, make_rec(target), if_out);
		check_word({name, " pc after target"}, target + 1, pc);
	endtask

	task automatic redirect_flush();
		apply_reset();
		clear_stream();
		pulse_start();
		wait_pc("redirect_flush jump", 3);
		redirect_once("redirect_flush jump", PC_JUMP, 12);
		wait_pc("redirect_flush branch", 14);
		redirect_once("redirect_flush branch", PC_BRANCH, 4);
		wait_pc("redirect_flush reg", 6);
		redirect_once("redirect_flush reg", PC_REG, 16);
		wait_halted("redirect_flush");
		// Jumped-over words never show up
		expect_range(0, 2);
		expect_range(12, 13);
		expect_range(4, 5);
		expect_range(16, PROG_LEN - 1);
		compare_stream("redirect_flush");
	endtask

	task automatic idle_only_loads();
		apply_reset();
		clear_stream();
		pulse_start();
		// Writes while running must be dropped
		repeat (6)
		begin
			load.we   = 1'b1;
			load.addr = $urandom % PROG_LEN;
			load.data = random_word();
			@(negedge clk);
		end
		load = '0;
		wait_halted("idle_only_loads run");
		expect_range(0, PROG_LEN - 1);
		compare_stream("idle_only_loads run");
		// Halt words written while halted
		for (int i = 0; i < 4; i++)
		begin
			load.we   = 1'b1;
			load.addr = i;
			load.data = HALT_WORD;
			@(negedge clk);
		end
		load = '0;
		apply_reset();
		check_bit("idle_only_loads halted cleared", 1'b0, halted);
		clear_stream();
		pulse_start();
		wait_halted("idle_only_loads rerun");
		expect_range(0, PROG_LEN - 1);
		compare_stream("idle_only_loads rerun");
		check_word("idle_only_loads halt pc", PROG_LEN, pc);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		reset = 1'b1;
		drive_idle();
		last_rec       = '0;
		value_errors   = 0;
		timeout_errors = 0;
		other_errors   = 0;
		assert_errors  = 0;
		void'($urandom(SEED));
		reset_defaults();
		load_and_run();
		stall_freeze();
		redirect_flush();
		idle_only_loads();
		// Failures of the bound controller assertions
		assert_errors = dut0.u_fetch_ctrl.chk0.fail_count;
		$display("error counts: %0d value, %0d timeout, %0d other, %0d assertion",
			value_errors, timeout_errors, other_errors, assert_errors);
		if ((value_errors + timeout_errors + other_errors + assert_errors) == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Hard limit on the whole run
	initial
	begin
		#(WATCHDOG_NS);
		$display("run did not finish within the time limit");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/fetch_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_chk
	import fetch_pkg::*;
(
	input wire logic         clk,
	input wire logic         reset,
	input wire fetch_state_e state,
	input wire logic         halted,
	input wire logic         mem_we,
	input wire logic         flush,
	input wire logic         if_valid
);

	// Number of assertion failures so far
	int fail_count;

	initial
	begin
		fail_count = 0;
	end

	//////////////////////////////////////////////////////////////////////
	// Controller properties
	//////////////////////////////////////////////////////////////////////

	// Halt is sticky, only reset clears it
	property halted_sticky;
		@(posedge clk) (halted && !reset) |=> halted;
	endproperty

	// Debug writes reach memory only while idle
	property write_only_idle;
		@(posedge clk) disable iff (reset) mem_we |-> (state == ST_IDLE);
	endproperty

	// Flush leaves a bubble in IF/ID
	property flush_bubble;
		@(posedge clk) disable iff (reset) flush |=> !if_valid;
	endproperty

	halted_sticky_a : assert property (halted_sticky)
	else
	begin
		fail_count++;
		$error("halted fell without reset");
	end

	write_only_idle_a : assert property (write_only_idle)
	else
	begin
		fail_count++;
		$error("memory write enable high outside idle state");
	end

	flush_bubble_a : assert property (flush_bubble)
	else
	begin
		fail_count++;
		$error("IF/ID output valid after a flush");
	end

endmodule

// Attached to every controller instance
// IF/ID valid and the memory write strobe are reached through the enclosing stage
bind fetch_ctrl fetch_chk chk0 (
	.clk      (clk),
	.reset    (reset),
	.state    (state),
	.halted   (halted),
	.mem_we   (u_instr_mem.we),
	.flush    (flush),
	.if_valid (u_if_id_reg.if_out.valid)
);

`default_nettype wire

/* verif/fetch_clkgen.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_clkgen #(
	parameter int PERIOD_NS = 20
) (
	output logic clk
);

	//////////////////////////////////////////////////////////////////////
	// Free running clock
	//////////////////////////////////////////////////////////////////////

	// Starts low so the first rising edge lands half a period in
	initial
	begin
		clk = 1'b0;
	end

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_stage
	import fetch_pkg::*;
#(
	parameter int MEM_DEPTH = 2048
) (
	input  wire logic      clk,
	input  wire logic      reset,
	input  wire logic      start,
	input  wire logic      stall,
	input  wire redirect_t redirect,
	input  wire load_t     load,
	output fetch_out_t     if_out,
	output logic           halted,
	output word_t          pc
);

	// Controller strobes
	logic advance;
	logic flush;
	logic mem_we;

	// Datapath between counter, memory and IF/ID
	word_t instr;
	word_t pc_plus_one;

	//////////////////////////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////////////////////////

	fetch_ctrl u_fetch_ctrl (
		.clk          (clk),
		.reset        (reset),
		.start        (start),
		.stall        (stall),
		.redirect_src (redirect.src),
		.instr        (instr),
		.load_we      (load.we),
		.advance      (advance),
		.flush        (flush),
		.mem_we       (mem_we),
		.halted       (halted)
	);

	//////////////////////////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////////////////////////

	// Program counter and next-PC mux
	pc_counter #(
		.MEM_DEPTH (MEM_DEPTH)
	) u_pc_counter (
		.clk         (clk),
		.reset       (reset),
		.advance     (advance),
		.redirect    (redirect),
		.pc          (pc),
		.pc_plus_one (pc_plus_one)
	);

	// Instruction store, debug writes while idle
	instr_mem #(
		.MEM_DEPTH (MEM_DEPTH)
	) u_instr_mem (
		.clk   (clk),
		.pc    (pc),
		.instr (instr),
		.we    (mem_we),
		.load  (load)
	);

	// Hand-off to decode
	if_id_reg u_if_id_reg (
		.clk         (clk),
		.reset       (reset),
		.advance     (advance),
		.flush       (flush),
		.instr       (instr),
		.pc_plus_one (pc_plus_one),
		.if_out      (if_out)
	);

endmodule

`default_nettype wire

/* src/if_id_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module if_id_reg
	import fetch_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  reset,
	input  wire logic  advance,
	input  wire logic  flush,
	input  wire word_t instr,
	input  wire word_t pc_plus_one,
	output fetch_out_t if_out
);

	// Record loaded on a normal advance
	fetch_out_t fetched;

	//////////////////////////////////////////////////////////////////////
	// Candidate records
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		fetched.instr       = instr;
		fetched.pc_plus_one = pc_plus_one;
		fetched.valid       = 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Pipeline register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			if_out <= '0;
		end
		else if (flush)
		begin
			// Flush wins over advance
			// Bubble is a NOP with valid low
			if_out.instr       <= NOP_WORD;
			if_out.pc_plus_one <= '0;
			if_out.valid       <= 1'b0;
		end
		else if (advance)
		begin
			if_out <= fetched;
		end
		// Stall or idle, hold
	end

endmodule

`default_nettype wire

/* src/fetch_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl
	import fetch_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    reset,
	input  wire logic    start,
	input  wire logic    stall,
	input  wire pc_src_e redirect_src,
	input  wire word_t   instr,
	input  wire logic    load_we,
	output logic         advance,
	output logic         flush,
	output logic         mem_we,
	output logic         halted
);

	// Current and next controller state
	fetch_state_e state;
	fetch_state_e state_next;

	// Halt word seen at the current PC
	logic halt_fetch;
	// Running in this cycle
	logic running;

	//////////////////////////////////////////////////////////////////////
	// Decode of the fetched word and the state
	//////////////////////////////////////////////////////////////////////

	// Only place that looks for the halt word
	assign halt_fetch = (instr == HALT_WORD);
	assign running    = (state == ST_RUN);

	// Step forward unless frozen or halting
	assign advance = running && !stall && !halt_fetch;

	// Redirect kills the word in flight
	// Halt also drops a bubble into IF/ID
	assign flush = (advance && (redirect_src != PC_SEQ)) || (running && halt_fetch);

	// Debug writes only while idle, dropped otherwise
	assign mem_we = load_we && (state == ST_IDLE);

	// Level, held until reset
	assign halted = (state == ST_HALTED);

	//////////////////////////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			// Waiting for the program load and a start pulse
			ST_IDLE:
			begin
				if (start)
				begin
					state_next = ST_RUN;
				end
			end
			// Fetching, stall or not
			ST_RUN:
			begin
				if (halt_fetch)
				begin
					state_next = ST_HALTED;
				end
			end
			// Stuck here, only reset gets out
			ST_HALTED:
			begin
				state_next = ST_HALTED;
			end
			// Unused encoding
			default:
			begin
				state_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
		end
		else
		begin
			state <= state_next;
		end
	end

endmodule

`default_nettype wire

/* fetch/instr_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_mem
	import fetch_pkg::*;
#(
	parameter int MEM_DEPTH = 2048
) (
	input  wire logic  clk,
	input  wire word_t pc,
	output word_t      instr,
	input  wire logic  we,
	input  wire load_t load
);

	// Index width, low bits of the word address
	localparam int ADDR_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

	// Program storage, filled through the debug port
	word_t mem [MEM_DEPTH];

	// Read and write indices
	logic [ADDR_W-1:0] rd_idx;
	logic [ADDR_W-1:0] wr_idx;

	assign rd_idx = pc[ADDR_W-1:0];
	assign wr_idx = load.addr[ADDR_W-1:0];

	//////////////////////////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////////////////////////

	// Asynchronous read, same cycle as the PC
	// Controller sees the word in time for halt detection
	assign instr = mem[rd_idx];

	//////////////////////////////////////////////////////////////////////
	// Debug write side
	//////////////////////////////////////////////////////////////////////

	// Strobe already qualified by the controller
	// Word written here is readable on the next cycle
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[wr_idx] <= load.data;
		end
	end

endmodule

`default_nettype wire

/* fetch/pc_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module pc_counter
	import fetch_pkg::*;
#(
	parameter int MEM_DEPTH = 2048
) (
	input  wire logic      clk,
	input  wire logic      reset,
	input  wire logic      advance,
	input  wire redirect_t redirect,
	output word_t          pc,
	output word_t          pc_plus_one
);

	// Index width of the instruction memory
	localparam int ADDR_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

	// Selected target before wrapping
	word_t target;
	// Target folded into the memory range
	word_t pc_next;

	//////////////////////////////////////////////////////////////////////
	// Next address selection
	//////////////////////////////////////////////////////////////////////

	// Word addressed, so sequential is plus one
	assign pc_plus_one = pc + word_t'(1);

	always_comb
	begin
		case (redirect.src)
			// Unconditional jump
			PC_JUMP:
			begin
				target = redirect.jump_target;
			end
			// Taken branch
			PC_BRANCH:
			begin
				target = redirect.branch_target;
			end
			// Jump through register
			PC_REG:
			begin
				target = redirect.reg_target;
			end
			// Plain sequential fetch
			default:
			begin
				target = pc_plus_one;
			end
		endcase
	end

	// Keep only the low index bits so the PC wraps within memory
	assign pc_next = word_t'(target[ADDR_W-1:0]);

	//////////////////////////////////////////////////////////////////////
	// PC register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
		end
		else if (advance)
		begin
			// Moves only when the controller lets the stage advance
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

/* common/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	//////////////////////////////////////////////////////////////////////
	// Word and instruction constants
	//////////////////////////////////////////////////////////////////////

	// Instruction and PC width
	localparam int WORD_W = 32;

	// One machine word, used for instructions and word addresses
	typedef logic [WORD_W-1:0] word_t;

	// All ones stops fetching until reset
	localparam word_t HALT_WORD = '1;
	// All zero, the bubble put into IF/ID on a flush
	localparam word_t NOP_WORD = '0;

	//////////////////////////////////////////////////////////////////////
	// Bundles crossing the stage boundary
	//////////////////////////////////////////////////////////////////////

	// Next-PC source select
	typedef enum logic [1:0] {
		PC_SEQ    = 2'd0,
		PC_JUMP   = 2'd1,
		PC_BRANCH = 2'd2,
		PC_REG    = 2'd3
	} pc_src_e;

	// Redirect request from later stages, sampled every cycle
	typedef struct packed {
		pc_src_e src;
		word_t   jump_target;
		word_t   branch_target;
		word_t   reg_target;
	} redirect_t;

	// Debug load port into instruction memory
	typedef struct packed {
		logic  we;
		word_t addr;
		word_t data;
	} load_t;

	// IF/ID register contents
	typedef struct packed {
		word_t instr;
		word_t pc_plus_one;
		logic  valid;
	} fetch_out_t;

	// Fetch controller states
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_RUN    = 2'd1,
		ST_HALTED = 2'd2
	} fetch_state_e;

endpackage

`default_nettype wire
